//--- include/clocking_config.svh
// Divider reset values are sized literals that must track CLK_DIV_W when it changes
`ifndef CLOCKING_CONFIG_SVH
`define CLOCKING_CONFIG_SVH

// Divider field width where a value of 0 behaves like 1
`define CLK_DIV_W 5
`define CLK_CORE_DIV_RST 5'd1
`define CLK_USER_DIV_RST 5'd2

// Housekeeping register port
`define HK_ADDR_W 3
`define HK_DATA_W 8

// Extra low cycles on core_rstn once the synchronizer lets go
`define CLK_RST_HOLD 4

`endif

//--- rtl/clk_pkg.sv
// Clock side types only and needs include/ on the include path for the divider width
`default_nettype none

`include "clocking_config.svh"

package clk_pkg;

	// Base enable source
	typedef enum logic [0:0] {
		SRC_EXT = 1'b0,	// System clock, every cycle
		SRC_PLL = 1'b1	// One enable per pll_tick pulse
	} clk_source_t;

	// Reset release sequencer
	typedef enum logic [1:0] {
		RST_HELD  = 2'd0,	// Some reset cause still active
		RST_COUNT = 2'd1,	// Synchronizer released, stretching
		RST_RUN   = 2'd2	// core_rstn high
	} rst_state_t;

	// One clocking setting as it travels between blocks
	typedef struct packed {
		clk_source_t           source;
		logic [`CLK_DIV_W-1:0] core_div;	// Base enables per core tick
		logic [`CLK_DIV_W-1:0] user_div;	// Core ticks per user tick
		logic                  ext_reset;	// Software reset request
	} clk_cfg_t;

endpackage

`default_nettype wire

//--- rtl/hk_pkg.sv
// Housekeeping register map with addresses 6 and 7 left unmapped and reading as zero
`default_nettype none

`include "clocking_config.svh"

package hk_pkg;

	typedef enum logic [`HK_ADDR_W-1:0] {
		HK_SRC      = 3'd0,	// Bit 0 selects the PLL
		HK_CORE_DIV = 3'd1,
		HK_USER_DIV = 3'd2,
		HK_EXT_RST  = 3'd3,	// Bit 0 holds the core in reset
		HK_LOCK     = 3'd4,	// Sticky until system reset
		HK_STATUS   = 3'd5	// Read only
	} hk_addr_t;

	// Registers that the lock freezes
	function automatic logic hk_lockable(hk_addr_t addr);
		return (addr == HK_SRC) || (addr == HK_CORE_DIV) || (addr == HK_USER_DIV);
	endfunction

	// Registers that feed the clocking setting
	function automatic logic hk_is_cfg(hk_addr_t addr);
		return hk_lockable(addr) || (addr == HK_EXT_RST);
	endfunction

endpackage

`default_nettype wire

//--- rtl/clk_ctrl_if.sv
// Plain strobe and level bundle with no acknowledge so a newer update replaces a pending one
`timescale 1ns/1ps
`default_nettype none

interface clk_ctrl_if;
	import clk_pkg::*;

	clk_cfg_t cfg;	// Setting, new in the update cycle
	logic     update;	// One cycle strobe
	logic     pending;	// Buffer still holds an unapplied setting

	// Register block side
	modport producer (
		output cfg,
		output update,
		input  pending
	);

	// Holding stage between register block and tick generator
	modport buffer (
		input  cfg,
		input  update,
		output pending
	);

	// Tick generator side
	modport consumer (
		input cfg,
		input update
	);

endinterface

`default_nettype wire

//--- rtl/hk_clock_regs.sv
// Lock blocks source and divider writes until system reset and back to back writes spread updates
`timescale 1ns/1ps
`default_nettype none

`include "clocking_config.svh"

module hk_clock_regs (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  reg_we,
	input  hk_pkg::hk_addr_t      reg_addr,
	input  logic [`HK_DATA_W-1:0] reg_wdata,
	output logic [`HK_DATA_W-1:0] reg_rdata,	// One cycle after reg_addr
	input  logic                  core_rstn,	// Reported in status bit 0
	clk_ctrl_if.producer          req
);
	import clk_pkg::*;
	import hk_pkg::*;

	clk_source_t           src_q;
	logic [`CLK_DIV_W-1:0] core_div_q;
	logic [`CLK_DIV_W-1:0] user_div_q;
	logic                  ext_rst_q;
	logic                  lock_q;
	logic                  wr_ok;	// Write accepted this cycle
	logic                  cfg_wr;	// Accepted write that touches the setting
	logic                  update_q;
	logic                  upd_due;	// Update owed after a busy strobe cycle
	logic [`HK_DATA_W-1:0] rdata_d;

	// Lockable fields need the lock clear while status and unmapped addresses never accept
	assign wr_ok  = reg_we && (hk_lockable(reg_addr) ? !lock_q :
		((reg_addr == HK_EXT_RST) || (reg_addr == HK_LOCK)));
	assign cfg_wr = wr_ok && hk_is_cfg(reg_addr);

	always_ff @(posedge clock) begin
		if (reset) begin
			src_q      <= SRC_EXT;
			core_div_q <= `CLK_CORE_DIV_RST;
			user_div_q <= `CLK_USER_DIV_RST;
			ext_rst_q  <= 1'b0;
			lock_q     <= 1'b0;
		end else if (wr_ok) begin
			case (reg_addr)
				HK_SRC:      src_q      <= clk_source_t'(reg_wdata[0]);
				HK_CORE_DIV: core_div_q <= reg_wdata[`CLK_DIV_W-1:0];
				HK_USER_DIV: user_div_q <= reg_wdata[`CLK_DIV_W-1:0];
				HK_EXT_RST:  ext_rst_q  <= reg_wdata[0];
				HK_LOCK:     lock_q     <= lock_q | reg_wdata[0];	// Cannot be cleared
				default:     lock_q     <= lock_q;
			endcase
		end
	end

	// Strobe one cycle after the write
	// A write landing on a strobe cycle defers its strobe by one
	always_ff @(posedge clock) begin
		if (reset) begin
			update_q <= 1'b0;
			upd_due  <= 1'b0;
		end else begin
			update_q <= (cfg_wr || upd_due) && !update_q;
			upd_due  <= (cfg_wr || upd_due) && update_q;
		end
	end

	always_comb begin
		case (reg_addr)
			HK_SRC:      rdata_d = {{(`HK_DATA_W-1){1'b0}}, src_q};
			HK_CORE_DIV: rdata_d = {{(`HK_DATA_W-`CLK_DIV_W){1'b0}}, core_div_q};
			HK_USER_DIV: rdata_d = {{(`HK_DATA_W-`CLK_DIV_W){1'b0}}, user_div_q};
			HK_EXT_RST:  rdata_d = {{(`HK_DATA_W-1){1'b0}}, ext_rst_q};
			HK_LOCK:     rdata_d = {{(`HK_DATA_W-1){1'b0}}, lock_q};
			HK_STATUS:   rdata_d = {{(`HK_DATA_W-2){1'b0}}, req.pending, core_rstn};
			default:     rdata_d = '0;	// Unmapped
		endcase
	end

	always_ff @(posedge clock) begin
		reg_rdata <= rdata_d;
	end

	// Registers always visible with update marking the cycle they changed
	assign req.cfg = '{source: src_q, core_div: core_div_q,
		user_div: user_div_q, ext_reset: ext_rst_q};
	assign req.update = update_q;

	// Buffer sees a quiet cycle between strobes
	a_upd_spaced: assert property (@(posedge clock) disable iff (reset)
		update_q |=> !update_q)
		else $error("hk_clock_regs update strobe in consecutive cycles");

endmodule

`default_nettype wire

//--- rtl/clk_switch_hold.sv
// Source and divider changes wait for a core tick with no timeout while ext_reset never waits
`timescale 1ns/1ps
`default_nettype none

`include "clocking_config.svh"

module clk_switch_hold (
	input  logic         clock,
	input  logic         reset,
	input  logic         core_tick,	// Safe boundary for a divider switch
	clk_ctrl_if.buffer   req,
	clk_ctrl_if.producer act
);
	import clk_pkg::*;

	clk_cfg_t req_q;	// Latest request, held until a tick
	clk_cfg_t next_cfg;
	clk_cfg_t act_cfg_q;	// Setting the tick generator runs on
	logic     pend_q;
	logic     act_upd_q;
	logic     apply;	// Move the request to the active side
	logic     ext_chg;	// Reset request edge from the register block

	// An update in the tick cycle itself is taken directly
	assign next_cfg = req.update ? req.cfg : req_q;
	assign apply    = core_tick && !act.pending && (pend_q || req.update);
	assign ext_chg  = req.update && (req.cfg.ext_reset != act_cfg_q.ext_reset);

	always_ff @(posedge clock) begin
		if (req.update)
			req_q <= req.cfg;	// Last write wins
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			act_cfg_q <= '{source: SRC_EXT, core_div: `CLK_CORE_DIV_RST,
				user_div: `CLK_USER_DIV_RST, ext_reset: 1'b0};
		end else begin
			if (apply) begin
				act_cfg_q.source   <= next_cfg.source;
				act_cfg_q.core_div <= next_cfg.core_div;
				act_cfg_q.user_div <= next_cfg.user_div;
			end
			// Reset request passes straight through
			if (req.update)
				act_cfg_q.ext_reset <= req.cfg.ext_reset;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pend_q    <= 1'b0;
			act_upd_q <= 1'b0;
		end else begin
			if (apply)
				pend_q <= 1'b0;
			else if (req.update)
				pend_q <= 1'b1;	// Waits for a tick, however long
			act_upd_q <= apply || ext_chg;	// Downstream restarts its counters
		end
	end

	assign req.pending = pend_q;
	assign act.cfg     = act_cfg_q;
	assign act.update  = act_upd_q;

	// Active side only changes on a tick boundary or a reset request edge
	a_upd_cause: assert property (@(posedge clock) disable iff (reset)
		act.update |-> $past(core_tick || ext_chg))
		else $error("clk_switch_hold active update without tick or reset edge");

	// A tick always drains the held setting
	a_drain: assert property (@(posedge clock) disable iff (reset)
		req.pending && core_tick |=> !req.pending)
		else $error("clk_switch_hold pending survived a core tick");

endmodule

`default_nettype wire

//--- rtl/clk_tick_gen.sv
// Ticks are one cycle enables on clock and resetb is synchronized with 2 flops plus CLK_RST_HOLD
`timescale 1ns/1ps
`default_nettype none

`include "clocking_config.svh"

module clk_tick_gen (
	input  logic           clock,
	input  logic           reset,
	input  logic           resetb,	// Pad reset, active low, not synchronous to clock
	input  logic           pll_tick,	// Enable pulse from the PLL
	clk_ctrl_if.consumer   act,
	output logic           core_tick,
	output logic           user_tick,
	output logic           core_rstn
);
	import clk_pkg::*;

	localparam int HOLD_W = $clog2(`CLK_RST_HOLD) + 1;
	localparam logic [`CLK_DIV_W-1:0] DIV_ONE = 'd1;
	localparam logic [HOLD_W-1:0] HOLD_ONE = 'd1;
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`CLK_RST_HOLD - 1);

	logic                  base_en;
	logic [`CLK_DIV_W-1:0] core_cnt;	// Base enables since last core tick
	logic [`CLK_DIV_W-1:0] user_cnt;	// Core ticks since last user tick
	logic                  core_end;
	logic                  user_end;
	logic                  core_fire;
	logic                  user_fire;
	logic                  core_tick_q;
	logic                  user_tick_q;
	logic [1:0]            sync_q;	// resetb synchronizer
	rst_state_t            rst_state;
	logic [HOLD_W-1:0]     hold_cnt;
	logic                  rst_cause;

	assign base_en = (act.cfg.source == SRC_PLL) ? pll_tick : 1'b1;

	// Divider of 0 or 1 fires on every enable
	assign core_end  = (act.cfg.core_div <= DIV_ONE) ||
		(core_cnt >= act.cfg.core_div - DIV_ONE);
	assign user_end  = (act.cfg.user_div <= DIV_ONE) ||
		(user_cnt >= act.cfg.user_div - DIV_ONE);
	assign core_fire = base_en && core_end;
	assign user_fire = core_fire && user_end;	// User tick rides on a core tick

	always_ff @(posedge clock) begin
		if (reset || act.update) begin	// New setting restarts both dividers
			core_cnt    <= '0;
			user_cnt    <= '0;
			core_tick_q <= 1'b0;
			user_tick_q <= 1'b0;
		end else begin
			core_tick_q <= core_fire;
			user_tick_q <= user_fire;
			if (base_en)
				core_cnt <= core_end ? '0 : core_cnt + DIV_ONE;
			if (core_fire)
				user_cnt <= user_end ? '0 : user_cnt + DIV_ONE;
		end
	end

	assign core_tick = core_tick_q;
	assign user_tick = user_tick_q;

	assign rst_cause = reset || act.cfg.ext_reset;

	always_ff @(posedge clock) begin
		if (rst_cause)
			sync_q <= '0;
		else
			sync_q <= {sync_q[0], resetb};
	end

	// Stretch the synchronized release by CLK_RST_HOLD cycles
	always_ff @(posedge clock) begin
		if (rst_cause || !sync_q[1]) begin
			rst_state <= RST_HELD;
			hold_cnt  <= '0;
		end else begin
			case (rst_state)
				RST_HELD: begin
					rst_state <= RST_COUNT;
					hold_cnt  <= HOLD_ONE;	// Release edge is the first hold cycle
				end
				RST_COUNT: begin
					if (hold_cnt == HOLD_LAST)
						rst_state <= RST_RUN;
					else
						hold_cnt <= hold_cnt + HOLD_ONE;
				end
				RST_RUN:   rst_state <= RST_RUN;
				default:   rst_state <= RST_HELD;
			endcase
		end
	end

	assign core_rstn = (rst_state == RST_RUN);

	// Ticks from the two dividers stay aligned
	a_user_in_core: assert property (@(posedge clock) disable iff (reset)
		user_tick |-> core_tick)
		else $error("clk_tick_gen user_tick without core_tick");

	// Software reset request reaches the core within a cycle
	a_ext_reset: assert property (@(posedge clock) disable iff (reset)
		act.cfg.ext_reset |=> !core_rstn)
		else $error("clk_tick_gen core_rstn high under ext_reset");

endmodule

`default_nettype wire

//--- rtl/mgmt_clocking.sv
// Single clock domain with divided clocks as enables and no handshake on any internal path
`timescale 1ns/1ps
`default_nettype none

`include "clocking_config.svh"

module mgmt_clocking (
	input  logic                  clock,
	input  logic                  reset,	// Synchronous, active high
	input  logic                  resetb,	// Pad reset, active low
	input  logic                  pll_tick,
	input  logic                  reg_we,
	input  hk_pkg::hk_addr_t      reg_addr,
	input  logic [`HK_DATA_W-1:0] reg_wdata,
	output logic [`HK_DATA_W-1:0] reg_rdata,
	output logic                  core_tick,
	output logic                  user_tick,
	output logic                  core_rstn
);

	clk_ctrl_if if_req ();	// Register block to holding stage
	clk_ctrl_if if_act ();	// Holding stage to tick generator

	// Tick generator applies at once
	assign if_act.pending = 1'b0;

	hk_clock_regs u_regs (
		.clock     (clock),
		.reset     (reset),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.core_rstn (core_rstn),
		.req       (if_req)
	);

	clk_switch_hold u_hold (
		.clock     (clock),
		.reset     (reset),
		.core_tick (core_tick),	// Switch boundary from the generator
		.req       (if_req),
		.act       (if_act)
	);

	clk_tick_gen u_ticks (
		.clock     (clock),
		.reset     (reset),
		.resetb    (resetb),
		.pll_tick  (pll_tick),
		.act       (if_act),
		.core_tick (core_tick),
		.user_tick (user_tick),
		.core_rstn (core_rstn)
	);

endmodule

`default_nettype wire

//--- bench/mgmt_clocking_tb.sv
// Enables on one clock with a seeded random pll_tick and intervals counted by the bench itself
`timescale 1ns/1ps
`default_nettype none

`include "clocking_config.svh"

module mgmt_clocking_tb;
	import hk_pkg::*;

	localparam bit [31:0] SEED = 32'ha4de;
	localparam int CYCLES_PER_STEP = 400;
	localparam int CYCLES_EXTRA = 200;	// Reset release and external reset sequence

	typedef struct packed {
		hk_addr_t              addr;
		logic [`HK_DATA_W-1:0] wdata;
		logic                  we;
		logic [`HK_DATA_W-1:0] rd_exp;	// Readback once the step settled
		int                    core_iv;	// Base enables per core tick
		int                    user_iv;	// Core ticks per user tick
	} step_t;

	logic                  clock;
	logic                  reset;
	logic                  resetb;
	logic                  pll_tick;
	logic                  reg_we;
	hk_addr_t              reg_addr;
	logic [`HK_DATA_W-1:0] reg_wdata;
	logic [`HK_DATA_W-1:0] reg_rdata;
	logic                  core_tick;
	logic                  user_tick;
	logic                  core_rstn;

	step_t     steps[$];
	int        cycle_cnt;
	int        cycle_limit;
	bit [31:0] rnd_word;
	bit        pll_mode;	// Source the bench expects on the active side
	bit        lock_model;

	mgmt_clocking u_dut (
		.clock     (clock),
		.reset     (reset),
		.resetb    (resetb),
		.pll_tick  (pll_tick),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.core_tick (core_tick),
		.user_tick (user_tick),
		.core_rstn (core_rstn)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period
	end

	// PLL enable on about half of the cycles
	initial begin
		void'($urandom(SEED));
		pll_tick <= 1'b0;
		forever begin
			@(posedge clock);
			rnd_word = $urandom();
			pll_tick <= rnd_word[0];
		end
	end

	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clock);
			cycle_cnt = cycle_cnt + 1;
			if (cycle_cnt > cycle_limit)
				abort_run("Run stopped at the cycle limit before the last step");
		end
	end

	task abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task check_equal(input string name, input int got, input int want);
		assert (got == want)
		else abort_run($sformatf("Fail %s got %0h expected %0h", name, got, want));
	endtask

	task add_step(input hk_addr_t addr, input logic [`HK_DATA_W-1:0] wdata, input logic we,
		input logic [`HK_DATA_W-1:0] rd_exp, input int core_iv, input int user_iv);
		step_t s;
		s.addr    = addr;
		s.wdata   = wdata;
		s.we      = we;
		s.rd_exp  = rd_exp;
		s.core_iv = core_iv;
		s.user_iv = user_iv;
		steps.push_back(s);
	endtask

	task build_table;
		// Reset values, read only
		add_step(HK_SRC, 8'h00, 1'b0, 8'h00, 1, 2);
		add_step(HK_CORE_DIV, 8'h00, 1'b0, 8'h01, 1, 2);
		add_step(HK_USER_DIV, 8'h00, 1'b0, 8'h02, 1, 2);
		// System clock as base
		add_step(HK_CORE_DIV, 8'h03, 1'b1, 8'h03, 3, 2);
		add_step(HK_USER_DIV, 8'h04, 1'b1, 8'h04, 3, 4);
		add_step(HK_CORE_DIV, 8'h07, 1'b1, 8'h07, 7, 4);
		add_step(HK_USER_DIV, 8'h05, 1'b1, 8'h05, 7, 5);
		add_step(HK_CORE_DIV, 8'h00, 1'b1, 8'h00, 1, 5);	// Zero behaves as one
		add_step(HK_USER_DIV, 8'h01, 1'b1, 8'h01, 1, 1);
		add_step(HK_CORE_DIV, 8'h01, 1'b1, 8'h01, 1, 1);
		// Intervals now in pll_tick pulses
		add_step(HK_SRC, 8'h01, 1'b1, 8'h01, 1, 1);
		add_step(HK_CORE_DIV, 8'h23, 1'b1, 8'h03, 3, 1);	// Upper bits dropped
		add_step(HK_USER_DIV, 8'h04, 1'b1, 8'h04, 3, 4);
		add_step(HK_SRC, 8'h00, 1'b1, 8'h00, 3, 4);
		// Lock, then writes that must not land
		add_step(HK_LOCK, 8'h01, 1'b1, 8'h01, 3, 4);
		add_step(HK_CORE_DIV, 8'h07, 1'b1, 8'h03, 3, 4);
		add_step(hk_addr_t'(3'd6), 8'hff, 1'b1, 8'h00, 3, 4);	// Unmapped
	endtask

	task write_reg(input hk_addr_t addr, input logic [`HK_DATA_W-1:0] data);
		@(posedge clock);
		reg_we    <= 1'b1;
		reg_addr  <= addr;
		reg_wdata <= data;
		@(posedge clock);
		reg_we   <= 1'b0;
		reg_addr <= HK_STATUS;	// Poll status from here
	endtask

	// Pending shows in readback two cycles after the write strobe
	task wait_idle;
		repeat (2) @(posedge clock);
		@(negedge clock);
		while (reg_rdata[1])
			@(negedge clock);
	endtask

	task read_check(input hk_addr_t addr, input logic [`HK_DATA_W-1:0] want);
		@(posedge clock);
		reg_addr <= addr;
		@(posedge clock);	// Registered readback
		@(negedge clock);
		check_equal("reg_rdata", int'(reg_rdata), int'(want));
	endtask

	// core_tick in a cycle comes from the base enable one cycle earlier
	task measure_ticks(input int core_want, input int user_want);
		int skipped;
		int n_core;
		int n_user;
		int en_cnt;
		int since_user;
		bit user_seen;
		skipped    = 0;
		n_core     = 0;
		n_user     = 0;
		since_user = 0;
		while (skipped < 2) begin
			@(negedge clock);
			if (core_tick)
				skipped = skipped + 1;
		end
		en_cnt    = (!pll_mode || pll_tick) ? 1 : 0;	// Count from the second skipped tick
		user_seen = user_tick;
		while (n_core < 4 || n_user < 4) begin
			@(negedge clock);
			if (core_tick) begin
				if (n_core < 4)
					check_equal("core_tick interval", en_cnt, core_want);
				n_core     = n_core + 1;
				en_cnt     = 0;
				since_user = since_user + 1;
			end
			if (!pll_mode || pll_tick)
				en_cnt = en_cnt + 1;
			if (user_tick) begin
				if (user_seen && n_user < 4) begin
					check_equal("user_tick interval", since_user, user_want);
					n_user = n_user + 1;
				end
				user_seen  = 1'b1;	// First user tick only opens the window
				since_user = 0;
			end
		end
	endtask

	task run_step(input step_t s);
		if (s.we) begin
			write_reg(s.addr, s.wdata);
			if (s.addr == HK_SRC && !lock_model)
				pll_mode = s.wdata[0];
			if (s.addr == HK_LOCK && s.wdata[0])
				lock_model = 1'b1;	// Sticky until reset
		end else begin
			@(posedge clock);
			reg_addr <= HK_STATUS;
		end
		wait_idle();
		read_check(s.addr, s.rd_exp);
		measure_ticks(s.core_iv, s.user_iv);
	endtask

	// 2 synchronizer cycles plus 4 hold cycles
	task check_reset_release;
		int n;
		repeat (7) @(posedge clock);
		@(negedge clock);
		check_equal("core_rstn", int'(core_rstn), 0);
		check_equal("core_tick", int'(core_tick), 0);
		check_equal("user_tick", int'(user_tick), 0);
		@(posedge clock);
		reset  <= 1'b0;	// Eighth edge still sees reset
		resetb <= 1'b1;
		n = 0;
		@(negedge clock);
		while (!core_rstn && n < 20) begin
			n = n + 1;
			@(negedge clock);
		end
		check_equal("core_rstn release cycles", n, 6);
	endtask

	task check_ext_reset;
		int n;
		write_reg(HK_EXT_RST, 8'h01);
		@(negedge clock);
		n = 1;
		while (core_rstn && n < 8) begin
			@(negedge clock);
			n = n + 1;
		end
		check_equal("core_rstn", int'(core_rstn), 0);
		wait_idle();
		check_equal("reg_rdata status bit 0", int'(reg_rdata[0]), 0);
		write_reg(HK_EXT_RST, 8'h00);
		@(negedge clock);
		n = 1;
		while (!core_rstn && n < 8) begin	// Buffer, strobe and release path
			@(negedge clock);
			n = n + 1;
		end
		check_equal("core_rstn", int'(core_rstn), 1);
		wait_idle();
		check_equal("reg_rdata status bit 0", int'(reg_rdata[0]), 1);
		read_check(HK_EXT_RST, 8'h00);
		measure_ticks(3, 4);	// Ticks run on with the locked setting
	endtask

	initial begin
		reset      <= 1'b1;
		resetb     <= 1'b0;
		reg_we     <= 1'b0;
		reg_addr   <= HK_SRC;
		reg_wdata  <= '0;
		pll_mode   = 1'b0;
		lock_model = 1'b0;
		build_table();
		cycle_limit = CYCLES_PER_STEP * steps.size() + CYCLES_EXTRA;
		check_reset_release();
		foreach (steps[i])
			run_step(steps[i]);
		check_ext_reset();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- mgmt_clocking.f
+incdir+include
rtl/clk_pkg.sv
rtl/hk_pkg.sv
rtl/clk_ctrl_if.sv
rtl/hk_clock_regs.sv
rtl/clk_switch_hold.sv
rtl/clk_tick_gen.sv
rtl/mgmt_clocking.sv
bench/mgmt_clocking_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module mgmt_clocking_tb \
	-f mgmt_clocking.f \
	--Mdir obj_dir -o mgmt_clocking_sim

./obj_dir/mgmt_clocking_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation passed" sim.log; then
	echo "Result: pass"
else
	echo "Result: fail"
	exit 1
fi
